// ==== design/controlEncoder.sv ====
`include "mipsControl_cfg.svh"

module controlEncoder
    import mipsControlPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  stateT                 state,
    input  logic [`STEP_W-1:0]    step,
    input  opKindT                opKind,
    input  logic                  eq,
    output logic                  memWrite,
    output logic                  irWrite,
    output logic                  pcWrite,
    output logic                  regWrite,
    output logic                  regAWrite,
    output logic                  regBWrite,
    output logic                  aluOutWrite,
    output logic                  mdrWrite,
    output logic                  epcWrite,
    output logic                  resetOut,
    output aluOpT                 aluOp,
    output pcSourceT              pcSource,
    output exCauseT               exCause,
    output logic [`IORD_W-1:0]    iorD,
    output logic [`REGDST_W-1:0]  regDst,
    output logic [`DATASRC_W-1:0] dataSrc,
    output logic [`ALUSRCA_W-1:0] aluSrcA,
    output logic [`ALUSRCB_W-1:0] aluSrcB,
    output memSizeT               loadSize,
    output memSizeT               storeSize
);

    localparam logic [`STEP_W-1:0] irLoadStep = `FETCH_LOAD_STEP;
    localparam logic [`STEP_W-1:0] regFetchStep = `FETCH_LOAD_STEP + 1;
    localparam logic [`STEP_W-1:0] memLastStep = `MEM_WAIT + 1;

    // Datapath mux codes
    localparam logic [`IORD_W-1:0] iorDAluOut = 3'b110;
    localparam logic [`REGDST_W-1:0] regDstRt = 2'b00;
    localparam logic [`REGDST_W-1:0] regDstSp = 2'b10;
    localparam logic [`REGDST_W-1:0] regDstRd = 2'b11;
    localparam logic [`DATASRC_W-1:0] dsAluOut = 3'b000;
    localparam logic [`DATASRC_W-1:0] dsStackTop = 3'b100;
    localparam logic [`DATASRC_W-1:0] dsLui = 3'b101;
    localparam logic [`DATASRC_W-1:0] dsMem = 3'b111;
    localparam logic [`ALUSRCA_W-1:0] srcAPc = 2'b01;
    localparam logic [`ALUSRCA_W-1:0] srcAReg = 2'b10;
    localparam logic [`ALUSRCB_W-1:0] srcBReg = 2'b00;
    localparam logic [`ALUSRCB_W-1:0] srcBFour = 2'b01;
    localparam logic [`ALUSRCB_W-1:0] srcBImm = 2'b10;
    localparam logic [`ALUSRCB_W-1:0] srcBBranch = 2'b11;

    function automatic aluOpT aluOpOf(input opKindT kind);
        case (kind)
            opSub: return aluSub;
            opAnd: return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    function automatic memSizeT sizeOf(input opKindT kind);
        case (kind)
            opLoadWord, opStoreWord: return sizeWord;
            opLoadHalf, opStoreHalf: return sizeHalf;
            opLoadByte, opStoreByte: return sizeByte;
            default: return sizeNone;
        endcase
    endfunction

    always_comb begin
        memWrite = 1'b0;
        irWrite = 1'b0;
        pcWrite = 1'b0;
        regWrite = 1'b0;
        regAWrite = 1'b0;
        regBWrite = 1'b0;
        aluOutWrite = 1'b0;
        mdrWrite = 1'b0;
        epcWrite = 1'b0;
        resetOut = 1'b0;
        aluOp = aluNone;
        pcSource = pcAlu;
        exCause = causeNone;
        iorD = '0;
        regDst = regDstRt;
        dataSrc = dsAluOut;
        aluSrcA = '0;
        aluSrcB = srcBReg;
        loadSize = sizeNone;
        storeSize = sizeNone;
        case (state)
            stReset: begin
                // Stack pointer gets its initial value
                resetOut = 1'b1;
                regWrite = 1'b1;
                regDst = regDstSp;
                dataSrc = dsStackTop;
            end
            stFetch: begin
                if (step <= irLoadStep) begin
                    aluOp = aluAdd;
                    pcSource = pcIncr;
                    aluSrcA = srcAPc;
                    aluSrcB = srcBFour;
                    if (step == irLoadStep) begin
                        irWrite = 1'b1;
                        pcWrite = 1'b1;
                    end
                end else if (step == regFetchStep) begin
                    // Registers read, branch target into ALUOut
                    aluOp = aluAdd;
                    aluSrcA = srcAPc;
                    aluSrcB = srcBBranch;
                    regAWrite = 1'b1;
                    regBWrite = 1'b1;
                    aluOutWrite = 1'b1;
                end
            end
            stAlu: begin
                if (step == '0) begin
                    aluOp = aluOpOf(opKind);
                    aluSrcA = srcAReg;
                    aluSrcB = srcBReg;
                    aluOutWrite = 1'b1;
                end else begin
                    regWrite = 1'b1;
                    regDst = regDstRd;
                    dataSrc = dsAluOut;
                end
            end
            stLoad, stStore: begin
                if (step == '0) begin
                    aluOp = aluAdd;
                    aluSrcA = srcAReg;
                    aluSrcB = srcBImm;
                    aluOutWrite = 1'b1;
                end else begin
                    iorD = iorDAluOut;
                    if (step == memLastStep && state == stLoad) begin
                        regWrite = 1'b1;
                        regDst = regDstRt;
                        dataSrc = dsMem;
                        loadSize = sizeOf(opKind);
                    end else if (step == memLastStep) begin
                        memWrite = 1'b1;
                        storeSize = sizeOf(opKind);
                    end
                end
            end
            stLui: begin
                regWrite = 1'b1;
                regDst = regDstRt;
                dataSrc = dsLui;
            end
            stBranch: begin
                aluOp = aluSub;
                aluSrcA = srcAReg;
                aluSrcB = srcBReg;
                pcSource = pcAlu;
                pcWrite = (opKind == opBne) ? !eq : eq;
            end
            stBreak: begin
                // PC minus 4 straight from the ALU
                aluOp = aluSub;
                aluSrcA = srcAPc;
                aluSrcB = srcBFour;
                pcSource = pcIncr;
                pcWrite = 1'b1;
            end
            stRte: begin
                pcSource = pcEpc;
                pcWrite = 1'b1;
            end
            stOverflow, stIllegal: begin
                epcWrite = 1'b1;
                pcWrite = 1'b1;
                pcSource = pcException;
                exCause = (state == stOverflow) ? causeOverflow : causeIllegal;
            end
            default: begin
            end
        endcase
    end

    noMemAndRegWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(memWrite && regWrite))
        else $error("memWrite and regWrite high together");

    // IR load always comes with the PC increment
    irLoadAdvancesPc: assert property (@(posedge clk) disable iff (!rstN)
        irWrite |-> pcWrite)
        else $error("irWrite without pcWrite");

endmodule

// ==== design/controlSequencer.sv ====
`include "mipsControl_cfg.svh"

module controlSequencer
    import mipsControlPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  opKindT             opKind,
    input  logic               overflow,
    output stateT              state,
    output logic [`STEP_W-1:0] step
);

    localparam logic [`STEP_W-1:0] fetchLastStep = `FETCH_STEPS - 1;
    localparam logic [`STEP_W-1:0] aluLastStep = 1;
    // Address step, wait steps, then the data step
    localparam logic [`STEP_W-1:0] memLastStep = `MEM_WAIT + 1;

    stateT              nextState;
    logic [`STEP_W-1:0] lastStep;
    logic               atLast;

    function automatic stateT dispatch(input opKindT kind);
        stateT target;
        case (kind)
            opAdd, opSub, opAnd: begin
                target = stAlu;
            end
            opLoadWord, opLoadHalf, opLoadByte: begin
                target = stLoad;
            end
            opStoreWord, opStoreHalf, opStoreByte: begin
                target = stStore;
            end
            opLui: begin
                target = stLui;
            end
            opBeq, opBne: begin
                target = stBranch;
            end
            opBreak: begin
                target = stBreak;
            end
            opRte: begin
                target = stRte;
            end
            opSoftReset: begin
                target = stReset;
            end
            default: begin
                target = stIllegal;
            end
        endcase
        return target;
    endfunction

    // Final step index of the current state
    always_comb begin
        case (state)
            stFetch: lastStep = fetchLastStep;
            stAlu: lastStep = aluLastStep;
            stLoad, stStore: lastStep = memLastStep;
            default: lastStep = '0;
        endcase
    end

    assign atLast = (step == lastStep);

    always_comb begin
        nextState = state;
        case (state)
            stFetch: begin
                if (atLast) begin
                    nextState = dispatch(opKind);
                end
            end
            stAlu: begin
                // Overflow only matters for add and sub, on the ALU step
                if (step == '0 && overflow && (opKind == opAdd || opKind == opSub)) begin
                    nextState = stOverflow;
                end else if (atLast) begin
                    nextState = stFetch;
                end
            end
            default: begin
                if (atLast) begin
                    nextState = stFetch;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stReset;
            step <= '0;
        end else begin
            state <= nextState;
            if (nextState != state) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (!rstN) step <= lastStep)
        else $error("step %0d passed the last step of state %s", step, state.name());

endmodule

// ==== design/instrDecoder.sv ====
module instrDecoder
    import mipsControlPkg::*;
(
    input  opcodeT opcode,
    input  functT  funct,
    output opKindT opKind
);

    always_comb begin
        opKind = opIllegal;
        case (opcode)
            opcRType: begin
                case (funct)
                    fnAdd: begin
                        opKind = opAdd;
                    end
                    fnSub: begin
                        opKind = opSub;
                    end
                    fnAnd: begin
                        opKind = opAnd;
                    end
                    fnBreak: begin
                        opKind = opBreak;
                    end
                    fnRte: begin
                        opKind = opRte;
                    end
                    default: begin
                        opKind = opIllegal;
                    end
                endcase
            end
            opcLw: begin
                opKind = opLoadWord;
            end
            opcLh: begin
                opKind = opLoadHalf;
            end
            opcLb: begin
                opKind = opLoadByte;
            end
            opcSw: begin
                opKind = opStoreWord;
            end
            opcSh: begin
                opKind = opStoreHalf;
            end
            opcSb: begin
                opKind = opStoreByte;
            end
            opcLui: begin
                opKind = opLui;
            end
            opcBeq: begin
                opKind = opBeq;
            end
            opcBne: begin
                opKind = opBne;
            end
            // All-ones opcode restarts the unit
            opcSoftReset: begin
                opKind = opSoftReset;
            end
            default: begin
                opKind = opIllegal;
            end
        endcase
    end

endmodule

// ==== design/mipsControl.sv ====
`include "mipsControl_cfg.svh"

module mipsControl
    import mipsControlPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  opcodeT                opcode,
    input  functT                 funct,
    input  logic                  overflow,
    input  logic                  eq,
    output logic                  memWrite,
    output logic                  irWrite,
    output logic                  pcWrite,
    output logic                  regWrite,
    output logic                  regAWrite,
    output logic                  regBWrite,
    output logic                  aluOutWrite,
    output logic                  mdrWrite,
    output logic                  epcWrite,
    output logic                  resetOut,
    output aluOpT                 aluOp,
    output pcSourceT              pcSource,
    output exCauseT               exCause,
    output logic [`IORD_W-1:0]    iorD,
    output logic [`REGDST_W-1:0]  regDst,
    output logic [`DATASRC_W-1:0] dataSrc,
    output logic [`ALUSRCA_W-1:0] aluSrcA,
    output logic [`ALUSRCB_W-1:0] aluSrcB,
    output memSizeT               loadSize,
    output memSizeT               storeSize
);

    opKindT             opKind;
    stateT              state;
    logic [`STEP_W-1:0] step;

    instrDecoder decoder0 (
        .opcode (opcode),
        .funct  (funct),
        .opKind (opKind)
    );

    controlSequencer sequencer0 (
        .clk      (clk),
        .rstN     (rstN),
        .opKind   (opKind),
        .overflow (overflow),
        .state    (state),
        .step     (step)
    );

    controlEncoder encoder0 (
        .clk         (clk),
        .rstN        (rstN),
        .state       (state),
        .step        (step),
        .opKind      (opKind),
        .eq          (eq),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .pcWrite     (pcWrite),
        .regWrite    (regWrite),
        .regAWrite   (regAWrite),
        .regBWrite   (regBWrite),
        .aluOutWrite (aluOutWrite),
        .mdrWrite    (mdrWrite),
        .epcWrite    (epcWrite),
        .resetOut    (resetOut),
        .aluOp       (aluOp),
        .pcSource    (pcSource),
        .exCause     (exCause),
        .iorD        (iorD),
        .regDst      (regDst),
        .dataSrc     (dataSrc),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .loadSize    (loadSize),
        .storeSize   (storeSize)
    );

endmodule

// ==== design/mipsControlPkg.sv ====
`include "mipsControl_cfg.svh"

package mipsControlPkg;

    // Primary opcodes handled by the unit
    typedef enum logic [`OPCODE_W-1:0] {
        opcRType     = 6'b000000,
        opcBeq       = 6'b000100,
        opcBne       = 6'b000101,
        opcLui       = 6'b001111,
        opcLb        = 6'b100000,
        opcLh        = 6'b100001,
        opcLw        = 6'b100011,
        opcSb        = 6'b101000,
        opcSh        = 6'b101001,
        opcSw        = 6'b101011,
        opcSoftReset = 6'b111111
    } opcodeT;

    // R-type function codes
    typedef enum logic [`FUNCT_W-1:0] {
        fnBreak = 6'b001101,
        fnRte   = 6'b010011,
        fnAdd   = 6'b100000,
        fnSub   = 6'b100010,
        fnAnd   = 6'b100100
    } functT;

    // Memory ops carry their size in the kind itself
    typedef enum logic [3:0] {
        opAdd, opSub, opAnd,
        opLoadWord, opLoadHalf, opLoadByte,
        opStoreWord, opStoreHalf, opStoreByte,
        opLui, opBeq, opBne, opBreak, opRte,
        opIllegal, opSoftReset
    } opKindT;

    typedef enum logic [3:0] {
        stReset, stFetch, stAlu, stLoad, stStore, stLui,
        stBranch, stBreak, stRte, stOverflow, stIllegal
    } stateT;

    typedef enum logic [2:0] {
        aluNone = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3
    } aluOpT;

    // Shared by loadSize and storeSize
    typedef enum logic [1:0] {
        sizeNone = 2'd0,
        sizeWord = 2'd1,
        sizeByte = 2'd2,
        sizeHalf = 2'd3
    } memSizeT;

    typedef enum logic [1:0] {
        causeNone     = 2'd0,
        causeIllegal  = 2'd1,
        causeOverflow = 2'd2
    } exCauseT;

    typedef enum logic [1:0] {
        pcAlu       = 2'd0,
        pcIncr      = 2'd1,
        pcException = 2'd2,
        pcEpc       = 2'd3
    } pcSourceT;

endpackage

// ==== design/mipsControl_cfg.svh ====
`ifndef MIPS_CONTROL_CFG_SVH
`define MIPS_CONTROL_CFG_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// Step counter, wide enough for the longest state
`define STEP_W 3

// Fetch and decode take a fixed number of steps
`define FETCH_STEPS 6

// IR and PC load on this fetch step
`define FETCH_LOAD_STEP 3

// Wait cycles between address and data for lw/lh/lb and sw/sh/sb
`define MEM_WAIT 3

// Datapath select widths
`define IORD_W 3
`define REGDST_W 2
`define DATASRC_W 3
`define ALUSRCA_W 2
`define ALUSRCB_W 2

`endif

// ==== mipsControl.f ====
+incdir+design
design/mipsControlPkg.sv
design/instrDecoder.sv
design/controlSequencer.sv
design/controlEncoder.sv
design/mipsControl.sv
sim/mipsControlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module mipsControlTb -f mipsControl.f \
    --Mdir obj_dir -o mipsControlSim > build.log 2>&1 \
    && ./obj_dir/mipsControlSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0

// ==== sim/mipsControlTb.sv ====
`include "mipsControl_cfg.svh"

module mipsControlTb
    import mipsControlPkg::*;
();

    localparam int clkPeriod = 8;
    localparam int resetCycles = 5;
    localparam int numInstr = 150;
    localparam int timeoutCycles = resetCycles + numInstr * 16 + 100;

    // Bit positions in the packed strobe vector
    localparam int bitMemWrite = 9;
    localparam int bitIrWrite = 8;
    localparam int bitPcWrite = 7;
    localparam int bitRegWrite = 6;
    localparam int bitRegAWrite = 5;
    localparam int bitRegBWrite = 4;
    localparam int bitAluOutWrite = 3;
    localparam int bitEpcWrite = 1;
    localparam int bitResetOut = 0;

    localparam int selW = `IORD_W + `REGDST_W + `DATASRC_W + `ALUSRCA_W + `ALUSRCB_W;

    // Datapath select codes
    localparam logic [`IORD_W-1:0] iorDAluOut = 3'b110;
    localparam logic [`REGDST_W-1:0] dstRt = 2'b00;
    localparam logic [`REGDST_W-1:0] dstSp = 2'b10;
    localparam logic [`REGDST_W-1:0] dstRd = 2'b11;
    localparam logic [`DATASRC_W-1:0] fromAluOut = 3'b000;
    localparam logic [`DATASRC_W-1:0] fromStackTop = 3'b100;
    localparam logic [`DATASRC_W-1:0] fromLui = 3'b101;
    localparam logic [`DATASRC_W-1:0] fromMem = 3'b111;
    localparam logic [`ALUSRCA_W-1:0] aFromPc = 2'b01;
    localparam logic [`ALUSRCA_W-1:0] aFromReg = 2'b10;
    localparam logic [`ALUSRCB_W-1:0] bFromReg = 2'b00;
    localparam logic [`ALUSRCB_W-1:0] bFromFour = 2'b01;
    localparam logic [`ALUSRCB_W-1:0] bFromImm = 2'b10;
    localparam logic [`ALUSRCB_W-1:0] bFromBranch = 2'b11;

    logic clk;
    logic rstN;
    opcodeT opcode;
    functT funct;
    logic overflow;
    logic eq;
    logic memWrite, irWrite, pcWrite, regWrite, regAWrite, regBWrite;
    logic aluOutWrite, mdrWrite, epcWrite, resetOut;
    aluOpT aluOp;
    pcSourceT pcSource;
    exCauseT exCause;
    logic [`IORD_W-1:0] iorD;
    logic [`REGDST_W-1:0] regDst;
    logic [`DATASRC_W-1:0] dataSrc;
    logic [`ALUSRCA_W-1:0] aluSrcA;
    logic [`ALUSRCB_W-1:0] aluSrcB;
    memSizeT loadSize;
    memSizeT storeSize;

    logic [9:0] actStrobes;
    logic [9:0] expStrobes;
    logic [selW-1:0] actSelects;
    aluOpT expAlu;
    pcSourceT expPc;
    exCauseT expCause;
    memSizeT expLoad;
    memSizeT expStore;
    logic [`IORD_W-1:0] expIorD;
    logic [`REGDST_W-1:0] expRegDst;
    logic [`DATASRC_W-1:0] expDataSrc;
    logic [`ALUSRCA_W-1:0] expSrcA;
    logic [`ALUSRCB_W-1:0] expSrcB;

    logic [15:0] lfsr = 16'd24625;
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int failedTests = 0;

    // Instruction table, slot 14 is the illegal encoding
    opcodeT opcTable [16] = '{
        opcRType, opcRType, opcRType, opcLw, opcLh, opcLb, opcSw, opcSh,
        opcSb, opcLui, opcBeq, opcBne, opcRType, opcRType, opcodeT'(6'b000010), opcSoftReset
    };
    functT fnTable [16] = '{
        fnAdd, fnSub, fnAnd, fnAdd, fnAdd, fnAdd, fnAdd, fnAdd,
        fnAdd, fnAdd, fnAdd, fnAdd, fnBreak, fnRte, fnAdd, fnAdd
    };
    memSizeT sizeTable [16] = '{
        sizeNone, sizeNone, sizeNone, sizeWord, sizeHalf, sizeByte, sizeWord, sizeHalf,
        sizeByte, sizeNone, sizeNone, sizeNone, sizeNone, sizeNone, sizeNone, sizeNone
    };
    string nameTable [16] = '{
        "add", "sub", "and", "lw", "lh", "lb", "sw", "sh",
        "sb", "lui", "beq", "bne", "break", "rte", "illegal opcode", "soft reset"
    };

    mipsControl dut0 (
        .clk(clk), .rstN(rstN), .opcode(opcode), .funct(funct),
        .overflow(overflow), .eq(eq), .memWrite(memWrite), .irWrite(irWrite),
        .pcWrite(pcWrite), .regWrite(regWrite), .regAWrite(regAWrite),
        .regBWrite(regBWrite), .aluOutWrite(aluOutWrite), .mdrWrite(mdrWrite),
        .epcWrite(epcWrite), .resetOut(resetOut), .aluOp(aluOp), .pcSource(pcSource),
        .exCause(exCause), .iorD(iorD), .regDst(regDst), .dataSrc(dataSrc),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .loadSize(loadSize), .storeSize(storeSize)
    );

    assign actStrobes = {memWrite, irWrite, pcWrite, regWrite, regAWrite, regBWrite,
                         aluOutWrite, mdrWrite, epcWrite, resetOut};
    assign actSelects = {iorD, regDst, dataSrc, aluSrcA, aluSrcB};

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int count, output logic [7:0] value);
        value = '0;
        repeat (count) begin
            lfsr = lfsrStep(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic checkStrobes(input logic [9:0] expected, input logic [9:0] actual,
                                input string where);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s strobes expected %b got %b", $time, where, expected, actual);
        end
    endtask

    task automatic checkSelects(input logic [selW-1:0] expected, input logic [selW-1:0] actual,
                                input string where);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s selects expected %b got %b", $time, where, expected, actual);
        end
    endtask

    task automatic checkAlu(input aluOpT expected, input aluOpT actual, input string where);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s aluOp expected %s got %s",
                     $time, where, expected.name(), actual.name());
        end
    endtask

    task automatic checkPc(input pcSourceT expected, input pcSourceT actual, input string where);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s pcSource expected %s got %s",
                     $time, where, expected.name(), actual.name());
        end
    endtask

    task automatic checkSize(input memSizeT expected, input memSizeT actual, input string where);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s expected %s got %s",
                     $time, where, expected.name(), actual.name());
        end
    endtask

    task automatic checkCause(input exCauseT expected, input exCauseT actual, input string where);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s exCause expected %s got %s",
                     $time, where, expected.name(), actual.name());
        end
    endtask

    task automatic clearExpected();
        expStrobes = '0;
        expAlu = aluNone;
        expPc = pcAlu;
        expCause = causeNone;
        expLoad = sizeNone;
        expStore = sizeNone;
        expIorD = '0;
        expRegDst = dstRt;
        expDataSrc = fromAluOut;
        expSrcA = '0;
        expSrcB = bFromReg;
    endtask

    task automatic expectException(input exCauseT cause);
        expStrobes[bitEpcWrite] = 1'b1;
        expStrobes[bitPcWrite] = 1'b1;
        expPc = pcException;
        expCause = cause;
    endtask

    // Stack pointer load with the reset pulse
    task automatic expectResetStep();
        expStrobes[bitResetOut] = 1'b1;
        expStrobes[bitRegWrite] = 1'b1;
        expRegDst = dstSp;
        expDataSrc = fromStackTop;
    endtask

    // Sample mid-cycle, then return just after the next rising edge
    task automatic checkCycle(input string where);
        #4;
        checkStrobes(expStrobes, actStrobes, where);
        checkSelects({expIorD, expRegDst, expDataSrc, expSrcA, expSrcB}, actSelects, where);
        checkAlu(expAlu, aluOp, where);
        checkPc(expPc, pcSource, where);
        checkSize(expLoad, loadSize, {where, " loadSize"});
        checkSize(expStore, storeSize, {where, " storeSize"});
        checkCause(expCause, exCause, where);
        @(posedge clk);
        #1;
    endtask

    task automatic reportTest(input string what, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", testCount, what);
        end else begin
            failedTests++;
            $display("Test %0d %s: %0d errors", testCount, what, errorCount - errorsBefore);
        end
    endtask

    task automatic runInstr(input logic [3:0] slot, input logic ovf, input logic eqIn,
                            input logic altBit);
        string name;
        int errorsBefore;
        int i;
        errorsBefore = errorCount;
        name = nameTable[slot];
        opcode = opcTable[slot];
        funct = fnTable[slot];
        if (slot == 4'd14 && altBit) begin
            opcode = opcRType;
            funct = functT'(6'b000000);
            name = "illegal funct";
        end
        overflow = ovf;
        eq = eqIn;
        for (i = 0; i < `FETCH_STEPS; i++) begin
            clearExpected();
            if (i <= `FETCH_LOAD_STEP) begin
                expAlu = aluAdd;
                expPc = pcIncr;
                expSrcA = aFromPc;
                expSrcB = bFromFour;
            end
            if (i == `FETCH_LOAD_STEP) begin
                expStrobes[bitIrWrite] = 1'b1;
                expStrobes[bitPcWrite] = 1'b1;
            end else if (i == `FETCH_LOAD_STEP + 1) begin
                // Branch target goes into ALUOut with the register read
                expAlu = aluAdd;
                expSrcA = aFromPc;
                expSrcB = bFromBranch;
                expStrobes[bitRegAWrite] = 1'b1;
                expStrobes[bitRegBWrite] = 1'b1;
                expStrobes[bitAluOutWrite] = 1'b1;
            end
            checkCycle($sformatf("%s fetch step %0d", name, i));
        end
        clearExpected();
        case (slot)
            4'd0, 4'd1, 4'd2: begin
                expAlu = (slot == 4'd0) ? aluAdd : (slot == 4'd1) ? aluSub : aluAnd;
                expSrcA = aFromReg;
                expSrcB = bFromReg;
                expStrobes[bitAluOutWrite] = 1'b1;
                checkCycle({name, " execute"});
                clearExpected();
                if (ovf && slot != 4'd2) begin
                    expectException(causeOverflow);
                end else begin
                    expStrobes[bitRegWrite] = 1'b1;
                    expRegDst = dstRd;
                end
                checkCycle({name, " writeback"});
            end
            4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8: begin
                expAlu = aluAdd;
                expSrcA = aFromReg;
                expSrcB = bFromImm;
                expStrobes[bitAluOutWrite] = 1'b1;
                checkCycle({name, " address"});
                for (i = 0; i < `MEM_WAIT; i++) begin
                    clearExpected();
                    expIorD = iorDAluOut;
                    checkCycle($sformatf("%s wait %0d", name, i));
                end
                clearExpected();
                expIorD = iorDAluOut;
                if (slot <= 4'd5) begin
                    expStrobes[bitRegWrite] = 1'b1;
                    expDataSrc = fromMem;
                    expLoad = sizeTable[slot];
                end else begin
                    expStrobes[bitMemWrite] = 1'b1;
                    expStore = sizeTable[slot];
                end
                checkCycle({name, " data"});
            end
            4'd9: begin
                expStrobes[bitRegWrite] = 1'b1;
                expDataSrc = fromLui;
                checkCycle({name, " writeback"});
            end
            4'd10, 4'd11: begin
                expAlu = aluSub;
                expSrcA = aFromReg;
                expSrcB = bFromReg;
                expStrobes[bitPcWrite] = (slot == 4'd10) ? eqIn : !eqIn;
                checkCycle({name, " compare"});
            end
            4'd12: begin
                expAlu = aluSub;
                expPc = pcIncr;
                expSrcA = aFromPc;
                expSrcB = bFromFour;
                expStrobes[bitPcWrite] = 1'b1;
                checkCycle({name, " execute"});
            end
            4'd13: begin
                expPc = pcEpc;
                expStrobes[bitPcWrite] = 1'b1;
                checkCycle({name, " execute"});
            end
            4'd14: begin
                expectException(causeIllegal);
                checkCycle({name, " exception"});
            end
            default: begin
                expectResetStep();
                checkCycle({name, " reset step"});
            end
        endcase
        reportTest($sformatf("%s ovf=%b eq=%b", name, ovf, eqIn), errorsBefore);
    endtask

    initial begin
        logic [7:0] bits;
        logic [3:0] slot;
        logic ovf;
        logic eqIn;
        logic altBit;
        int errorsBefore;
        rstN = 1'b0;
        opcode = opcRType;
        funct = fnAdd;
        overflow = 1'b0;
        eq = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        errorsBefore = errorCount;
        clearExpected();
        expectResetStep();
        checkCycle("reset release");
        reportTest("reset release", errorsBefore);
        // First pass walks every slot once, then random picks
        for (int n = 0; n < numInstr; n++) begin
            if (n < 16) begin
                slot = n[3:0];
            end else begin
                takeBits(4, bits);
                slot = bits[3:0];
            end
            takeBits(1, bits);
            ovf = bits[0];
            takeBits(1, bits);
            eqIn = bits[0];
            takeBits(1, bits);
            altBit = bits[0];
            runInstr(slot, ovf, eqIn, altBit);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Watchdog timeout: the instruction stream did not finish in %0d cycles",
                 timeoutCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule
